// File: hw/fifo_bridge_cfg.svh
`ifndef FIFO_BRIDGE_CFG_SVH
`define FIFO_BRIDGE_CFG_SVH

////////////////////////////////////////////////////////////
// Bridge sizing
////////////////////////////////////////////////////////////

// Host FIFO word width in bits
`define BRIDGE_WORD_W 32

// Seven-segment digits on the board
`define BRIDGE_DIGITS 6

// One nibble per digit
`define BRIDGE_COUNT_W (4 * `BRIDGE_DIGITS)

`endif

// File: hw/fifo_bridge_pkg.sv
`include "fifo_bridge_cfg.svh"

package fifo_bridge_pkg;

	// One host FIFO word
	typedef logic [`BRIDGE_WORD_W-1:0] word_t;

	// Forwarded-word count, wraps at full width
	typedef logic [`BRIDGE_COUNT_W-1:0] count_t;

	// Segment pattern, active low, bit 0 is segment a
	typedef logic [6:0] seg_t;

	// Inbound pop sequence
	typedef enum logic [2:0] {
		RX_IDLE,
		RX_POP,
		RX_WAIT_DATA,
		RX_SETTLE_1,
		RX_SETTLE_2
	} rx_state_t;

	// Outbound push sequence
	typedef enum logic [1:0] {
		TX_IDLE,
		TX_PUSH,
		TX_RECOVER
	} tx_state_t;

endpackage

// File: hw/fifo_rx_reader.sv
`timescale 1ns/1ns
`include "fifo_bridge_cfg.svh"

module fifo_rx_reader
	import fifo_bridge_pkg::*;
(
	input  logic  CLOCK_50,
	input  logic  arst_n,
	input  logic  h2f_empty,
	input  word_t h2f_readdata,
	input  logic  hold_valid,
	output logic  h2f_read,
	output word_t rx_word,
	output logic  rx_strobe
);

	rx_state_t state;

	////////////////////////////////////////////////////////////
	// Pop sequence
	////////////////////////////////////////////////////////////

	// Idle -> pop -> wait -> settle -> settle -> idle
	// Five cycles minimum between pops
	always_ff @(posedge CLOCK_50 or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= RX_IDLE;
		end
		else
		begin
			case (state)
				RX_IDLE:
				begin
					// Data waiting and stage free
					if (!h2f_empty && !hold_valid)
					begin
						state <= RX_POP;
					end
				end
				RX_POP:       state <= RX_WAIT_DATA;
				RX_WAIT_DATA: state <= RX_SETTLE_1;
				RX_SETTLE_1:  state <= RX_SETTLE_2;
				RX_SETTLE_2:  state <= RX_IDLE;
				default:      state <= RX_IDLE;
			endcase
		end
	end

	// Single-cycle read request
	assign h2f_read = (state == RX_POP);

	// Word valid since the cycle after the pop
	// Sampled at the edge leaving wait_data
	always_ff @(posedge CLOCK_50)
	begin
		if (state == RX_WAIT_DATA)
		begin
			rx_word <= h2f_readdata;
		end
	end

	// Captured word is on rx_word during settle_1
	assign rx_strobe = (state == RX_SETTLE_1);

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	// Pop only decided on a non-empty FIFO
	a_no_pop_when_empty: assert property (
		@(posedge CLOCK_50) disable iff (!arst_n)
		$rose(h2f_read) |-> !$past(h2f_empty)
	);

	// Read strobe is one cycle wide
	a_read_single_cycle: assert property (
		@(posedge CLOCK_50) disable iff (!arst_n)
		h2f_read |=> !h2f_read
	);

endmodule

// File: hw/word_filter.sv
`timescale 1ns/1ns
`include "fifo_bridge_cfg.svh"

module word_filter
	import fifo_bridge_pkg::*;
(
	input  logic  CLOCK_50,
	input  logic  arst_n,
	input  word_t rx_word,
	input  logic  rx_strobe,
	input  logic  hold_taken,
	output word_t hold_word,
	output logic  hold_valid
);

	logic keep_word;

	// Zero words never go out
	assign keep_word = rx_strobe && (rx_word != {`BRIDGE_WORD_W{1'b0}});

	// One-word stage payload
	always_ff @(posedge CLOCK_50)
	begin
		if (keep_word)
		begin
			hold_word <= rx_word;
		end
	end

	// Valid until the writer takes it
	always_ff @(posedge CLOCK_50 or negedge arst_n)
	begin
		if (!arst_n)
		begin
			hold_valid <= 1'b0;
		end
		else if (keep_word)
		begin
			hold_valid <= 1'b1;
		end
		else if (hold_taken)
		begin
			hold_valid <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	// Reader holds off while the stage is full
	a_no_strobe_when_held: assert property (
		@(posedge CLOCK_50) disable iff (!arst_n)
		rx_strobe |-> !hold_valid
	);

	// Writer only takes a held word
	a_take_needs_valid: assert property (
		@(posedge CLOCK_50) disable iff (!arst_n)
		hold_taken |-> hold_valid
	);

endmodule

// File: hw/fifo_tx_writer.sv
`timescale 1ns/1ns
`include "fifo_bridge_cfg.svh"

module fifo_tx_writer
	import fifo_bridge_pkg::*;
(
	input  logic   CLOCK_50,
	input  logic   arst_n,
	input  word_t  hold_word,
	input  logic   hold_valid,
	input  logic   f2h_full,
	output logic   f2h_write,
	output word_t  f2h_writedata,
	output logic   hold_taken,
	output count_t fwd_count
);

	tx_state_t state;
	logic      start_push;

	// Held word and room downstream
	assign start_push = (state == TX_IDLE) && hold_valid && !f2h_full;

	////////////////////////////////////////////////////////////
	// Push sequence and count
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLOCK_50 or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state     <= TX_IDLE;
			fwd_count <= '0;
		end
		else
		begin
			case (state)
				TX_IDLE:
				begin
					if (start_push)
					begin
						state     <= TX_PUSH;
						// Wraps at count_t width
						fwd_count <= fwd_count + 1'b1;
					end
				end
				// Filter drops hold_valid during recover
				TX_PUSH:    state <= TX_RECOVER;
				TX_RECOVER: state <= TX_IDLE;
				default:    state <= TX_IDLE;
			endcase
		end
	end

	// Outbound data latched with the push decision
	always_ff @(posedge CLOCK_50)
	begin
		if (start_push)
		begin
			f2h_writedata <= hold_word;
		end
	end

	// Write and take share the push cycle
	assign f2h_write  = (state == TX_PUSH);
	assign hold_taken = (state == TX_PUSH);

	// Full seen at the deciding edge blocks the write
	a_no_write_when_full: assert property (
		@(posedge CLOCK_50) disable iff (!arst_n)
		f2h_write |-> !$past(f2h_full)
	);

endmodule

// File: hw/hex_display.sv
`timescale 1ns/1ns
`include "fifo_bridge_cfg.svh"

module hex_display
	import fifo_bridge_pkg::*;
(
	input  count_t fwd_count,
	output seg_t   hex0,
	output seg_t   hex1,
	output seg_t   hex2,
	output seg_t   hex3,
	output seg_t   hex4,
	output seg_t   hex5
);

	seg_t digit [`BRIDGE_DIGITS];

	////////////////////////////////////////////////////////////
	// Nibble to glyph
	////////////////////////////////////////////////////////////

	// Bit order gfedcba, a zero lights the segment
	function automatic seg_t hex_glyph(input logic [3:0] nib);
		seg_t glyph;
		case (nib)
			4'h0: glyph = 7'h40;
			4'h1: glyph = 7'h79;
			4'h2: glyph = 7'h24;
			4'h3: glyph = 7'h30;
			4'h4: glyph = 7'h19;
			4'h5: glyph = 7'h12;
			4'h6: glyph = 7'h02;
			4'h7: glyph = 7'h78;
			4'h8: glyph = 7'h00;
			4'h9: glyph = 7'h10;
			// Letters A to F, b and d lower case
			4'hA: glyph = 7'h08;
			4'hB: glyph = 7'h03;
			4'hC: glyph = 7'h46;
			4'hD: glyph = 7'h21;
			4'hE: glyph = 7'h06;
			4'hF: glyph = 7'h0E;
			default: glyph = 7'h7F;
		endcase
		return glyph;
	endfunction

	// One nibble per digit, digit 0 least significant
	always_comb
	begin
		for (int i = 0; i < `BRIDGE_DIGITS; i++)
		begin
			digit[i] = hex_glyph(fwd_count[4*i +: 4]);
		end
	end

	// Board digits
	assign hex0 = digit[0];
	assign hex1 = digit[1];
	assign hex2 = digit[2];
	assign hex3 = digit[3];
	assign hex4 = digit[4];
	assign hex5 = digit[5];

endmodule

// File: hw/fifo_bridge.sv
`timescale 1ns/1ns

module fifo_bridge
	import fifo_bridge_pkg::*;
(
	input  logic  CLOCK_50,
	input  logic  arst_n,
	// Host-to-fabric FIFO
	input  logic  h2f_empty,
	input  word_t h2f_readdata,
	output logic  h2f_read,
	// Fabric-to-host FIFO
	input  logic  f2h_full,
	output logic  f2h_write,
	output word_t f2h_writedata,
	// Count display
	output seg_t  hex0,
	output seg_t  hex1,
	output seg_t  hex2,
	output seg_t  hex3,
	output seg_t  hex4,
	output seg_t  hex5
);

	word_t  rx_word;
	logic   rx_strobe;
	word_t  hold_word;
	logic   hold_valid;
	logic   hold_taken;
	count_t fwd_count;

	// Inbound pop, stalls on a full stage
	fifo_rx_reader u_reader (
		.CLOCK_50     (CLOCK_50),
		.arst_n       (arst_n),
		.h2f_empty    (h2f_empty),
		.h2f_readdata (h2f_readdata),
		.hold_valid   (hold_valid),
		.h2f_read     (h2f_read),
		.rx_word      (rx_word),
		.rx_strobe    (rx_strobe)
	);

	// Zero drop and one-word stage
	word_filter u_filter (
		.CLOCK_50   (CLOCK_50),
		.arst_n     (arst_n),
		.rx_word    (rx_word),
		.rx_strobe  (rx_strobe),
		.hold_taken (hold_taken),
		.hold_word  (hold_word),
		.hold_valid (hold_valid)
	);

	// Outbound push and count
	fifo_tx_writer u_writer (
		.CLOCK_50      (CLOCK_50),
		.arst_n        (arst_n),
		.hold_word     (hold_word),
		.hold_valid    (hold_valid),
		.f2h_full      (f2h_full),
		.f2h_write     (f2h_write),
		.f2h_writedata (f2h_writedata),
		.hold_taken    (hold_taken),
		.fwd_count     (fwd_count)
	);

	hex_display u_display (
		.fwd_count (fwd_count),
		.hex0      (hex0),
		.hex1      (hex1),
		.hex2      (hex2),
		.hex3      (hex3),
		.hex4      (hex4),
		.hex5      (hex5)
	);

endmodule

// File: dv/fifo_bridge_tb.sv
`timescale 1ns/1ns

module fifo_bridge_tb
	import fifo_bridge_pkg::*;
();

	typedef word_t word_q_t [$];

	// Words sent over all phases
	localparam int TOTAL_WORDS = 230;
	localparam logic [1:0] FULL_LOW    = 2'd0;
	localparam logic [1:0] FULL_RANDOM = 2'd1;
	localparam logic [1:0] FULL_HIGH   = 2'd2;

	logic  CLOCK_50;
	logic  arst_n;
	logic  h2f_empty;
	word_t h2f_readdata;
	logic  h2f_read;
	logic  f2h_full;
	logic  f2h_write;
	word_t f2h_writedata;
	seg_t  hex0, hex1, hex2, hex3, hex4, hex5;

	// Host-side FIFO models and the sent history
	word_q_t    in_q;
	word_q_t    out_q;
	word_q_t    sent_q;
	logic [1:0] full_mode;
	int         full_left;
	logic       prev_read, prev_write, prev_empty, prev_full;

	fifo_bridge u_dut (
		.CLOCK_50      (CLOCK_50),
		.arst_n        (arst_n),
		.h2f_empty     (h2f_empty),
		.h2f_readdata  (h2f_readdata),
		.h2f_read      (h2f_read),
		.f2h_full      (f2h_full),
		.f2h_write     (f2h_write),
		.f2h_writedata (f2h_writedata),
		.hex0          (hex0),
		.hex1          (hex1),
		.hex2          (hex2),
		.hex3          (hex3),
		.hex4          (hex4),
		.hex5          (hex5)
	);

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	// Zero words dropped and order kept
	function automatic word_q_t expected_output(input word_q_t sent);
		word_q_t kept;
		foreach (sent[i])
		begin
			if (sent[i] != '0)
			begin
				kept.push_back(sent[i]);
			end
		end
		return kept;
	endfunction

	// Lit segments as gfedcba
	// Inverted for the active-low pins
	function automatic seg_t expected_glyph(input logic [3:0] nib);
		logic [6:0] lit;
		case (nib)
			4'h0: lit = 7'h3F;
			4'h1: lit = 7'h06;
			4'h2: lit = 7'h5B;
			4'h3: lit = 7'h4F;
			4'h4: lit = 7'h66;
			4'h5: lit = 7'h6D;
			4'h6: lit = 7'h7D;
			4'h7: lit = 7'h07;
			4'h8: lit = 7'h7F;
			4'h9: lit = 7'h6F;
			4'hA: lit = 7'h77;
			4'hB: lit = 7'h7C;
			4'hC: lit = 7'h39;
			4'hD: lit = 7'h5E;
			4'hE: lit = 7'h79;
			default: lit = 7'h71;
		endcase
		return ~lit;
	endfunction

	task automatic abort_run();
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	task automatic send_word(input word_t w);
		in_q.push_back(w);
		sent_q.push_back(w);
	endtask

	// Waits for an empty inbound queue and every expected output
	// Quiet tail lets a late write show up
	task automatic wait_drained();
		int want_n;
		want_n = expected_output(sent_q).size();
		while (in_q.size() != 0 || out_q.size() != want_n)
		begin
			@(posedge CLOCK_50);
		end
		repeat (12) @(posedge CLOCK_50);
		@(negedge CLOCK_50);
	endtask

	task automatic check_display(input count_t count);
		seg_t shown [6];
		seg_t want;
		shown[0] = hex0;
		shown[1] = hex1;
		shown[2] = hex2;
		shown[3] = hex3;
		shown[4] = hex4;
		shown[5] = hex5;
		for (int i = 0; i < 6; i++)
		begin
			want = expected_glyph(count[4*i +: 4]);
			assert (shown[i] === want) else
			begin
				$display("Fail hex%0d: got %h expected %h", i, shown[i], want);
				abort_run();
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// Clock, FIFO models and monitors
	////////////////////////////////////////////////////////////

	initial
	begin
		CLOCK_50 = 1'b0;
		forever #10 CLOCK_50 = ~CLOCK_50;
	end

	// Inputs move 2 ns after the edge
	initial
	begin
		logic pop_req;
		h2f_empty    = 1'b1;
		h2f_readdata = '0;
		f2h_full     = 1'b0;
		full_left    = 0;
		forever
		begin
			@(posedge CLOCK_50);
			pop_req = h2f_read;
			#2;
			// Popped word stays until the next pulse
			if (pop_req && arst_n)
			begin
				assert (in_q.size() != 0) h2f_readdata = in_q.pop_front();
				else
				begin
					$display("Read pulse arrived while the inbound FIFO was empty");
					abort_run();
				end
			end
			h2f_empty = (in_q.size() == 0);
			// Random full stretches
			if (full_mode == FULL_HIGH)
				f2h_full = 1'b1;
			else if (full_mode == FULL_RANDOM && full_left > 0)
				full_left--;
			else if (full_mode == FULL_RANDOM && ($urandom % 8) == 0)
				full_left = ($urandom % 6) + 1;
			if (full_mode != FULL_HIGH)
				f2h_full = (full_mode == FULL_RANDOM) && (full_left > 0);
		end
	end

	// Strobe rules on pre-edge values
	always @(posedge CLOCK_50)
	begin
		if (!arst_n)
		begin
			assert (!h2f_read && !f2h_write) else
			begin
				$display("Fail strobes in reset: h2f_read %h f2h_write %h", h2f_read, f2h_write);
				abort_run();
			end
		end
		else
		begin
			assert (!(h2f_read && prev_read)) else
			begin
				$display("h2f_read was high on two consecutive cycles");
				abort_run();
			end
			assert (!(f2h_write && prev_write)) else
			begin
				$display("f2h_write was high on two consecutive cycles");
				abort_run();
			end
			assert (!(h2f_read && !prev_read && prev_empty)) else
			begin
				$display("h2f_read rose after h2f_empty was high");
				abort_run();
			end
			assert (!(f2h_write && prev_full)) else
			begin
				$display("f2h_write came after f2h_full was high");
				abort_run();
			end
		end
		prev_read  = arst_n && h2f_read;
		prev_write = arst_n && f2h_write;
		prev_empty = h2f_empty;
		prev_full  = f2h_full;
	end

	// Outbound FIFO capture and comparison
	always @(posedge CLOCK_50)
	begin
		word_q_t want_q;
		if (arst_n && f2h_write)
		begin
			want_q = expected_output(sent_q);
			assert (out_q.size() < want_q.size()) else
			begin
				$display("A word was written beyond the expected list");
				abort_run();
			end
			assert (f2h_writedata === want_q[out_q.size()]) else
			begin
				$display("Fail f2h_writedata: got %h expected %h", f2h_writedata,
					want_q[out_q.size()]);
				abort_run();
			end
			out_q.push_back(f2h_writedata);
		end
	end

	initial
	begin
		repeat (TOTAL_WORDS * 40 + 2000) @(posedge CLOCK_50);
		$display("Watchdog expired before the tests finished");
		abort_run();
	end

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial
	begin
		word_t w;
		int    writes_before;
		void'($urandom(32'h538d));
		arst_n    = 1'b0;
		full_mode = FULL_LOW;
		repeat (4) @(posedge CLOCK_50);
		#2 arst_n = 1'b1;
		@(negedge CLOCK_50);
		check_display('0);

		// Mixed words with about a fifth zero
		// Random full gaps
		full_mode = FULL_RANDOM;
		for (int i = 0; i < 200; i++)
		begin
			w = (($urandom % 5) == 0) ? '0 : word_t'($urandom);
			send_word(w);
		end
		wait_drained();
		full_mode = FULL_LOW;
		check_display(count_t'(expected_output(sent_q).size()));

		// Zero-only burst leaves the count where it was
		for (int i = 0; i < 20; i++)
			send_word('0);
		wait_drained();
		check_display(count_t'(expected_output(sent_q).size()));

		// Full held for 50 cycles with words waiting
		full_mode = FULL_HIGH;
		repeat (2) @(negedge CLOCK_50);
		writes_before = out_q.size();
		for (int i = 0; i < 10; i++)
		begin
			do w = $urandom; while (w == '0);
			send_word(w);
		end
		repeat (50) @(negedge CLOCK_50);
		assert (out_q.size() == writes_before) else
		begin
			$display("Fail f2h_write count: got %h expected %h", out_q.size(), writes_before);
			abort_run();
		end
		assert (in_q.size() >= 8) else
		begin
			$display("More than two words left the inbound FIFO while f2h_full was high");
			abort_run();
		end
		full_mode = FULL_LOW;
		wait_drained();
		check_display(count_t'(expected_output(sent_q).size()));

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

// File: fifo_bridge.f
+incdir+hw
hw/fifo_bridge_pkg.sv
hw/fifo_rx_reader.sv
hw/word_filter.sv
hw/fifo_tx_writer.sv
hw/hex_display.sv
hw/fifo_bridge.sv
dv/fifo_bridge_tb.sv
